/* rtl/MipsIsaPkg.sv */
package MipsIsaPkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word layout
	////////////////////////////////////////////////////////////////////////////

	// Architectural widths
	localparam int regAddrWidth = 5;
	localparam int dataWidth = 32;

	// Link register for JAL
	localparam int ra = 31;

	// Low bit of each field
	localparam int opcodeLsb = 26;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;
	localparam int shamtLsb = 6;

	// Opcode, function, immediate and jump target widths
	localparam int fieldWidth = 6;
	localparam int immWidth = 16;
	localparam int targetWidth = 26;

	////////////////////////////////////////////////////////////////////////////
	// Primary opcodes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0]
	{
		opRType = 6'd0,
		opJ = 6'd2,
		opJal = 6'd3,
		opBeq = 6'd4,
		opBne = 6'd5,
		opAddi = 6'd8,
		opAddiu = 6'd9,
		opSlti = 6'd10,
		opAndi = 6'd12,
		opOri = 6'd13,
		opXori = 6'd14,
		opLui = 6'd15,
		opLb = 6'd32,
		opLh = 6'd33,
		opLw = 6'd35,
		opLbu = 6'd36,
		opLhu = 6'd37,
		opLwu = 6'd39,
		opSb = 6'd40,
		opSh = 6'd41,
		opSw = 6'd43
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0]
	{
		fnSll = 6'd0,
		fnSrl = 6'd2,
		fnSra = 6'd3,
		fnJr = 6'd8,
		fnAdd = 6'd32,
		fnAddu = 6'd33,
		fnSub = 6'd34,
		fnSubu = 6'd35,
		fnAnd = 6'd36,
		fnOr = 6'd37,
		fnXor = 6'd38,
		fnNor = 6'd39,
		fnSlt = 6'd42,
		fnSltu = 6'd43
	} functionT;

endpackage

/* rtl/MipsCtrlPkg.sv */
package MipsCtrlPkg;

	////////////////////////////////////////////////////////////////////////////
	// Decoder to datapath control encodings
	////////////////////////////////////////////////////////////////////////////

	// ALU operation class
	typedef enum logic [1:0]
	{
		aluAdd = 2'd0,   // Load and store addresses
		aluSub = 2'd1,   // Branch compare
		aluFunct = 2'd2, // From the function field
		aluImm = 2'd3    // From the opcode
	} aluOpT;

	// Destination register select
	typedef enum logic [1:0]
	{
		dstRt = 2'd0,
		dstRd = 2'd1,
		dstRa = 2'd2
	} regDstT;

	// Write-back source
	typedef enum logic [1:0]
	{
		wbAlu = 2'd0,
		wbMem = 2'd1,
		wbLink = 2'd2
	} memToRegT;

	// Load divider codes
	typedef enum logic [2:0]
	{
		ldWord = 3'd0,
		ldWordU = 3'd1,
		ldByte = 3'd2,
		ldByteU = 3'd3,
		ldHalf = 3'd4,
		ldHalfU = 3'd5
	} loadSizeT;

	// Store divider codes
	typedef enum logic [1:0]
	{
		stWord = 2'd0,
		stByte = 2'd1,
		stHalf = 2'd2
	} storeSizeT;

endpackage

/* rtl/ControlUnit.sv */
module ControlUnit
(
	input MipsIsaPkg::opcodeT opcode,
	input MipsIsaPkg::functionT funct,
	output logic branch,
	output logic branchOnEqual,
	output logic jump,
	output logic jumpReg,
	output logic memRead,
	output logic memWrite,
	output logic aluSrc,
	output logic regWrite,
	output MipsCtrlPkg::aluOpT aluOp,
	output MipsCtrlPkg::regDstT regDst,
	output MipsCtrlPkg::memToRegT memToReg,
	output MipsCtrlPkg::loadSizeT loadSize,
	output MipsCtrlPkg::storeSizeT storeSize
);
	import MipsIsaPkg::*;
	import MipsCtrlPkg::*;

	always_comb
	begin
		// Safe default, nothing written anywhere
		branch = 1'b0;
		branchOnEqual = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		aluSrc = 1'b0;
		regWrite = 1'b0;
		aluOp = aluAdd;
		regDst = dstRt;
		memToReg = wbAlu;
		loadSize = ldWord;
		storeSize = stWord;

		case (opcode)
			opRType:
			begin
				aluOp = aluFunct;
				regDst = dstRd;
				// JR redirects only, no register write
				if (funct == fnJr)
					jumpReg = 1'b1;
				else
					regWrite = 1'b1;
			end
			opAddi, opAddiu, opSlti, opAndi, opOri, opXori, opLui:
			begin
				aluOp = aluImm;
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			opLw, opLwu, opLb, opLbu, opLh, opLhu:
			begin
				aluSrc = 1'b1;
				memRead = 1'b1;
				regWrite = 1'b1;
				memToReg = wbMem;
				// Divider code per load width
				case (opcode)
					opLwu: loadSize = ldWordU;
					opLb: loadSize = ldByte;
					opLbu: loadSize = ldByteU;
					opLh: loadSize = ldHalf;
					opLhu: loadSize = ldHalfU;
					default: loadSize = ldWord;
				endcase
			end
			opSw, opSb, opSh:
			begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
				if (opcode == opSb)
					storeSize = stByte;
				else if (opcode == opSh)
					storeSize = stHalf;
			end
			opBeq, opBne:
			begin
				branch = 1'b1;
				aluOp = aluSub;
				branchOnEqual = (opcode == opBeq);
			end
			opJ:
				jump = 1'b1;
			opJal:
			begin
				// Link to ra with PC+4
				jump = 1'b1;
				regWrite = 1'b1;
				regDst = dstRa;
				memToReg = wbLink;
			end
			default:
			begin
			end
		endcase
	end

endmodule

/* rtl/RegisterFile.sv */
module RegisterFile
(
	input logic clk,
	input logic reset,
	input logic [MipsIsaPkg::regAddrWidth-1:0] readAddrA,
	input logic [MipsIsaPkg::regAddrWidth-1:0] readAddrB,
	input logic [MipsIsaPkg::regAddrWidth-1:0] writeAddr,
	input logic [MipsIsaPkg::dataWidth-1:0] writeData,
	input logic writeEnable,
	output logic [MipsIsaPkg::dataWidth-1:0] readDataA,
	output logic [MipsIsaPkg::dataWidth-1:0] readDataB
);
	import MipsIsaPkg::*;

	logic [dataWidth-1:0] regs [2**regAddrWidth];

	// Write on the edge, register zero never written
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2**regAddrWidth; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	// Combinational reads, zero hardwired
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

/* rtl/Alu.sv */
module Alu
(
	input MipsCtrlPkg::aluOpT aluOp,
	input MipsIsaPkg::opcodeT opcode,
	input MipsIsaPkg::functionT funct,
	input logic [MipsIsaPkg::regAddrWidth-1:0] shamt,
	input logic [MipsIsaPkg::dataWidth-1:0] operandA,
	input logic [MipsIsaPkg::dataWidth-1:0] operandB,
	output logic [MipsIsaPkg::dataWidth-1:0] result,
	output logic zero
);
	import MipsIsaPkg::*;
	import MipsCtrlPkg::*;

	// Resolved operation
	typedef enum logic [3:0]
	{
		opAdd, opSub, opAnd, opOr, opXor, opNor,
		opSlt, opSltu, opSll, opSrl, opSra, opLuiOp
	} aluFnT;

	aluFnT op;

	////////////////////////////////////////////////////////////////////////////
	// Operation decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		op = opAdd;
		case (aluOp)
			aluSub: op = opSub;
			aluFunct:
				case (funct)
					fnSub, fnSubu: op = opSub;
					fnAnd: op = opAnd;
					fnOr: op = opOr;
					fnXor: op = opXor;
					fnNor: op = opNor;
					fnSlt: op = opSlt;
					fnSltu: op = opSltu;
					fnSll: op = opSll;
					fnSrl: op = opSrl;
					fnSra: op = opSra;
					default: op = opAdd; // ADD, ADDU, JR
				endcase
			aluImm:
				case (opcode)
					opSlti: op = opSlt;
					opAndi: op = opAnd;
					opOri: op = opOr;
					opXori: op = opXor;
					opLui: op = opLuiOp;
					default: op = opAdd; // ADDI, ADDIU
				endcase
			default: op = opAdd;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Compute
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op)
			opSub: result = operandA - operandB;
			opAnd: result = operandA & operandB;
			opOr: result = operandA | operandB;
			opXor: result = operandA ^ operandB;
			opNor: result = ~(operandA | operandB);
			opSlt: result = dataWidth'($signed(operandA) < $signed(operandB));
			opSltu: result = dataWidth'(operandA < operandB);
			// Shifts act on rt
			opSll: result = operandB << shamt;
			opSrl: result = operandB >> shamt;
			opSra: result = $unsigned($signed(operandB) >>> shamt);
			opLuiOp: result = {operandB[immWidth-1:0], {immWidth{1'b0}}};
			default: result = operandA + operandB;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* rtl/MemoryAligner.sv */
module MemoryAligner
(
	input MipsCtrlPkg::loadSizeT loadSize,
	input MipsCtrlPkg::storeSizeT storeSize,
	input logic [MipsIsaPkg::dataWidth-1:0] address,
	input logic [MipsIsaPkg::dataWidth-1:0] storeData,
	input logic [MipsIsaPkg::dataWidth-1:0] memReadData,
	output logic [MipsIsaPkg::dataWidth-1:0] memWriteData,
	output logic [3:0] byteEnable,
	output logic [MipsIsaPkg::dataWidth-1:0] loadData
);
	import MipsCtrlPkg::*;

	logic [1:0] lane;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;

	assign lane = address[1:0];

	////////////////////////////////////////////////////////////////////////////
	// Store lane steering
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (storeSize)
			stByte:
			begin
				// Byte on every lane, one enable
				memWriteData = {4{storeData[7:0]}};
				byteEnable = 4'b0001 << lane;
			end
			stHalf:
			begin
				memWriteData = {2{storeData[15:0]}};
				byteEnable = lane[1] ? 4'b1100 : 4'b0011;
			end
			default:
			begin
				memWriteData = storeData;
				byteEnable = 4'b1111;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Load extraction, little endian
	////////////////////////////////////////////////////////////////////////////

	assign loadByte = memReadData[8*lane +: 8];
	assign loadHalf = lane[1] ? memReadData[31:16] : memReadData[15:0];

	always_comb
	begin
		case (loadSize)
			ldByte: loadData = {{24{loadByte[7]}}, loadByte};
			ldByteU: loadData = {24'b0, loadByte};
			ldHalf: loadData = {{16{loadHalf[15]}}, loadHalf};
			ldHalfU: loadData = {16'b0, loadHalf};
			// LW and LWU identical on 32 bits
			default: loadData = memReadData;
		endcase
	end

endmodule

/* rtl/MipsCore.sv */
module MipsCore
(
	input logic clk,
	input logic reset,
	input logic [MipsIsaPkg::dataWidth-1:0] imemData,
	input logic [MipsIsaPkg::dataWidth-1:0] dmemReadData,
	output logic [MipsIsaPkg::dataWidth-1:0] imemAddr,
	output logic [MipsIsaPkg::dataWidth-1:0] dmemAddr,
	output logic [MipsIsaPkg::dataWidth-1:0] dmemWriteData,
	output logic [3:0] dmemByteEnable,
	output logic dmemWrite,
	output logic dmemRead
);
	import MipsIsaPkg::*;
	import MipsCtrlPkg::*;

	// Instruction fields
	opcodeT opcode;
	functionT funct;
	logic [regAddrWidth-1:0] rs, rt, rd, shamt;
	logic [immWidth-1:0] imm;
	logic [targetWidth-1:0] target;

	// Control
	logic branch, branchOnEqual, jump, jumpReg;
	logic memRead, memWrite, aluSrc, regWrite;
	aluOpT aluOp;
	regDstT regDst;
	memToRegT memToReg;
	loadSizeT loadSize;
	storeSizeT storeSize;

	// Datapath
	logic [dataWidth-1:0] pc, pcPlus4, nextPc, branchTarget, jumpTarget;
	logic [dataWidth-1:0] extImm, rsData, rtData, aluB, aluResult;
	logic [dataWidth-1:0] loadData, writeBack;
	logic [regAddrWidth-1:0] writeReg;
	logic zero, branchTaken;

	assign opcode = opcodeT'(imemData[opcodeLsb +: fieldWidth]);
	assign funct = functionT'(imemData[fieldWidth-1:0]);
	assign rs = imemData[rsLsb +: regAddrWidth];
	assign rt = imemData[rtLsb +: regAddrWidth];
	assign rd = imemData[rdLsb +: regAddrWidth];
	assign shamt = imemData[shamtLsb +: regAddrWidth];
	assign imm = imemData[immWidth-1:0];
	assign target = imemData[targetWidth-1:0];

	ControlUnit control
	(
		.opcode(opcode), .funct(funct),
		.branch(branch), .branchOnEqual(branchOnEqual), .jump(jump), .jumpReg(jumpReg),
		.memRead(memRead), .memWrite(memWrite), .aluSrc(aluSrc), .regWrite(regWrite),
		.aluOp(aluOp), .regDst(regDst), .memToReg(memToReg),
		.loadSize(loadSize), .storeSize(storeSize)
	);

	////////////////////////////////////////////////////////////////////////////
	// Program counter
	////////////////////////////////////////////////////////////////////////////

	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {extImm[dataWidth-3:0], 2'b00};
	assign jumpTarget = {pcPlus4[31:28], target, 2'b00};
	// Taken when compare result matches the branch sense
	assign branchTaken = branch && (zero == branchOnEqual);

	always_comb
	begin
		if (jumpReg)
			nextPc = rsData;
		else if (jump)
			nextPc = jumpTarget;
		else if (branchTaken)
			nextPc = branchTarget;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else
			pc <= nextPc;
	end

	assign imemAddr = pc;

	// Logic immediates zero-extended, rest sign-extended
	always_comb
	begin
		if (opcode == opAndi || opcode == opOri || opcode == opXori)
			extImm = {{immWidth{1'b0}}, imm};
		else
			extImm = {{immWidth{imm[immWidth-1]}}, imm};
	end

	////////////////////////////////////////////////////////////////////////////
	// Register file, ALU, memory
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (regDst)
			dstRd: writeReg = rd;
			dstRa: writeReg = regAddrWidth'(ra);
			default: writeReg = rt;
		endcase
	end

	always_comb
	begin
		case (memToReg)
			wbMem: writeBack = loadData;
			wbLink: writeBack = pcPlus4;
			default: writeBack = aluResult;
		endcase
	end

	RegisterFile regFile
	(
		.clk(clk), .reset(reset),
		.readAddrA(rs), .readAddrB(rt),
		.writeAddr(writeReg), .writeData(writeBack), .writeEnable(regWrite),
		.readDataA(rsData), .readDataB(rtData)
	);

	assign aluB = aluSrc ? extImm : rtData;

	Alu alu
	(
		.aluOp(aluOp), .opcode(opcode), .funct(funct), .shamt(shamt),
		.operandA(rsData), .operandB(aluB),
		.result(aluResult), .zero(zero)
	);

	MemoryAligner aligner
	(
		.loadSize(loadSize), .storeSize(storeSize),
		.address(aluResult), .storeData(rtData), .memReadData(dmemReadData),
		.memWriteData(dmemWriteData), .byteEnable(dmemByteEnable), .loadData(loadData)
	);

	// Word address toward the memory, lanes by byte enables
	assign dmemAddr = aluResult;
	assign dmemRead = memRead;
	// No store while held in reset
	assign dmemWrite = memWrite && !reset;

endmodule

/* include/MipsProgram.svh */
`ifndef MIPS_PROGRAM_SVH
`define MIPS_PROGRAM_SVH

////////////////////////////////////////////////////////////////////////////
// Instruction encoding
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] encodeR(input int rs, input int rt, input int rd, input int sh,
	input functionT fn);
	return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic logic [31:0] encodeI(input opcodeT op, input int rs, input int rt,
	input int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

// Target is the word index of the destination
function automatic logic [31:0] encodeJ(input opcodeT op, input int index);
	return {op, 26'(index)};
endfunction

// Little-endian views of the initial data image
function automatic logic [7:0] memByte(input int addr);
	return dmem[addr[9:0]];
endfunction

function automatic logic [15:0] memHalf(input int addr);
	return {memByte(addr + 1), memByte(addr)};
endfunction

function automatic logic [31:0] memWord(input int addr);
	return {memHalf(addr + 2), memHalf(addr)};
endfunction

task automatic emit(input logic [31:0] word);
	imem[progLen] = word;
	progLen++;
endtask

task automatic expectStore(input int addr, input logic [3:0] be, input logic [31:0] data);
	expQ.push_back({32'(addr), be, data});
endtask

// SW of a register into the next result slot
task automatic storeResult(input int src, input logic [31:0] value);
	emit(encodeI(opSw, 20, src, resultSlot * 4));
	expectStore(resultBase + resultSlot * 4, 4'b1111, value);
	resultSlot++;
endtask

// Must never execute, its address marks it
task automatic emitSkippedStore();
	emit(encodeI(opSw, 0, 1, skipAddr));
endtask

////////////////////////////////////////////////////////////////////////////
// Test program
////////////////////////////////////////////////////////////////////////////

task automatic buildProgram();
	int off;
	int link;
	logic [7:0] b;
	logic [15:0] h;
	progLen = 0;
	resultSlot = 0;
	// r20 results, r21 load data, r22 sub-word stores
	emit(encodeI(opAddiu, 0, 20, resultBase));
	emit(encodeI(opAddiu, 0, 21, dataBase));
	emit(encodeI(opAddiu, 0, 22, storeBase));
	// r1 = -5 sign-extended, r2 = 0x8003 zero-extended
	emit(encodeI(opAddi, 0, 1, 'hFFFB));
	emit(encodeI(opOri, 0, 2, 'h8003));
	emit(encodeR(1, 2, 3, 0, fnAdd));
	storeResult(3, 32'h0000_7FFE);
	emit(encodeR(1, 2, 3, 0, fnSub));
	storeResult(3, 32'hFFFF_7FF8);
	emit(encodeR(2, 1, 3, 0, fnSubu));
	storeResult(3, 32'h0000_8008);
	emit(encodeR(1, 2, 3, 0, fnAnd));
	storeResult(3, 32'h0000_8003);
	emit(encodeR(1, 2, 3, 0, fnXor));
	storeResult(3, 32'hFFFF_7FF8);
	emit(encodeR(1, 2, 3, 0, fnNor));
	storeResult(3, 32'h0000_0004);
	// Same operands, signed then unsigned compare
	emit(encodeR(1, 2, 3, 0, fnSlt));
	storeResult(3, 32'h0000_0001);
	emit(encodeR(1, 2, 3, 0, fnSltu));
	storeResult(3, 32'h0000_0000);
	emit(encodeR(0, 2, 3, 20, fnSll));
	storeResult(3, 32'h0030_0000);
	emit(encodeR(0, 1, 3, 4, fnSrl));
	storeResult(3, 32'h0FFF_FFFF);
	emit(encodeR(0, 1, 3, 2, fnSra));
	storeResult(3, 32'hFFFF_FFFE);
	emit(encodeI(opLui, 0, 4, 'hA5C3));
	emit(encodeI(opXori, 4, 4, 'hF00F));
	storeResult(4, 32'hA5C3_F00F);
	emit(encodeI(opAndi, 1, 5, 'hFF00));
	storeResult(5, 32'h0000_FF00);
	emit(encodeR(2, 5, 3, 0, fnOr));
	storeResult(3, 32'h0000_FF03);
	emit(encodeI(opSlti, 1, 6, 'hFFFC));
	storeResult(6, 32'h0000_0001);
	// Write to r0 is dropped
	emit(encodeR(1, 2, 0, 0, fnAddu));
	storeResult(0, 32'h0000_0000);

	// Byte loads at every lane
	for (off = 0; off < 4; off++)
	begin
		b = memByte(dataBase + off);
		emit(encodeI(opLb, 21, 7, off));
		storeResult(7, {{24{b[7]}}, b});
		emit(encodeI(opLbu, 21, 7, off));
		storeResult(7, {24'b0, b});
	end
	for (off = 0; off < 4; off += 2)
	begin
		h = memHalf(dataBase + off);
		emit(encodeI(opLh, 21, 7, off));
		storeResult(7, {{16{h[15]}}, h});
		emit(encodeI(opLhu, 21, 7, off));
		storeResult(7, {16'b0, h});
	end
	emit(encodeI(opLw, 21, 7, 4));
	storeResult(7, memWord(dataBase + 4));
	emit(encodeI(opLwu, 21, 7, 8));
	storeResult(7, memWord(dataBase + 8));

	// Sub-word stores of r4, one lane or lane pair each
	for (off = 0; off < 4; off++)
	begin
		emit(encodeI(opSb, 22, 4, off));
		expectStore(storeBase + off, 4'b0001 << off, 32'h0000_000F << (8 * off));
	end
	for (off = 0; off < 4; off += 2)
	begin
		emit(encodeI(opSh, 22, 4, off));
		expectStore(storeBase + off, 4'b0011 << off, 32'h0000_F00F << (8 * off));
	end

	// Branches, taken ones skip one store
	emit(encodeI(opBeq, 2, 2, 1));
	emitSkippedStore();
	emit(encodeI(opBne, 2, 2, 1));
	storeResult(2, 32'h0000_8003);
	emit(encodeI(opBne, 1, 2, 1));
	emitSkippedStore();
	emit(encodeI(opBeq, 1, 2, 1));
	storeResult(1, 32'hFFFF_FFFB);

	// J, JAL and JR over one skipped store each
	emit(encodeJ(opJ, progLen + 2));
	emitSkippedStore();
	storeResult(2, 32'h0000_8003);
	link = progLen * 4 + 4;
	emit(encodeJ(opJal, progLen + 2));
	emitSkippedStore();
	storeResult(31, link);
	emit(encodeI(opAddiu, 0, 8, (progLen + 3) * 4));
	emit(encodeR(8, 0, 0, 0, fnJr));
	emitSkippedStore();
	storeResult(2, 32'h0000_8003);

	// Final loop on itself
	haltAddr = progLen * 4;
	emit(encodeJ(opJ, progLen));
endtask

`endif

/* verification/MipsCoreTb.sv */
module MipsCoreTb;
	timeunit 1ns;
	timeprecision 100ps;

	import MipsIsaPkg::*;

	localparam int clockPeriod = 40;
	localparam int driveDelay = 5;
	localparam int resetCycles = 4;
	localparam logic [31:0] seedValue = 32'hafc8_7e69;

	// Data memory map
	localparam int dataBase = 'h100;
	localparam int resultBase = 'h200;
	localparam int storeBase = 'h300;
	localparam int skipAddr = 'h3F0;

	typedef struct packed
	{
		logic [31:0] addr;
		logic [3:0] be;
		logic [31:0] data;
	} storeT;

	logic clk;
	logic reset;
	logic [31:0] imemData;
	logic [31:0] dmemReadData;
	logic [31:0] imemAddr;
	logic [31:0] dmemAddr;
	logic [31:0] dmemWriteData;
	logic [3:0] dmemByteEnable;
	logic dmemWrite;
	logic dmemRead;

	// Word-wide instruction memory, byte-wide data memory
	logic [31:0] imem [256];
	logic [7:0] dmem [1024];

	storeT expQ [$];
	storeT expected;
	logic [31:0] laneMask;
	int progLen;
	int resultSlot;
	int haltAddr;
	int storesSeen;
	int valueErrors;
	int otherErrors;
	integer seed;
	logic [31:0] rnd;
	logic resetSeen;

	`include "MipsProgram.svh"

	MipsCore DUT
	(
		.clk(clk), .reset(reset),
		.imemData(imemData), .dmemReadData(dmemReadData),
		.imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData),
		.dmemByteEnable(dmemByteEnable), .dmemWrite(dmemWrite), .dmemRead(dmemRead)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory models
	////////////////////////////////////////////////////////////////////////////

	// Same-cycle reads
	assign imemData = imem[imemAddr[9:2]];
	assign dmemReadData = {dmem[{dmemAddr[9:2], 2'd3}], dmem[{dmemAddr[9:2], 2'd2}],
		dmem[{dmemAddr[9:2], 2'd1}], dmem[{dmemAddr[9:2], 2'd0}]};

	// Write on the edge, enabled lanes only
	always @(posedge clk)
	begin
		if (dmemWrite)
			for (int lane = 0; lane < 4; lane++)
				if (dmemByteEnable[lane])
					dmem[{dmemAddr[9:2], lane[1:0]}] <= dmemWriteData[8*lane +: 8];
	end

	initial
	begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Load opcodes of the ISA, the only ones that read data memory
	function automatic logic readsDataMemory(input logic [31:0] instr);
		case (instr[31:26])
			opLb, opLh, opLw, opLbu, opLhu, opLwu: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Every store against the next expected one
	always @(posedge clk)
	begin
		if (!reset && dmemWrite)
		begin
			if (dmemAddr == skipAddr)
			begin
				otherErrors++;
				$display("Store from an instruction that a branch or jump should have skipped");
			end
			else if (expQ.size() == 0)
			begin
				otherErrors++;
				$display("Unexpected store to address %h after the last expected store", dmemAddr);
			end
			else
			begin
				expected = expQ.pop_front();
				laneMask = {{8{expected.be[3]}}, {8{expected.be[2]}},
					{8{expected.be[1]}}, {8{expected.be[0]}}};
				storesSeen++;
				assert (dmemAddr == expected.addr && dmemByteEnable == expected.be
					&& (dmemWriteData & laneMask) == (expected.data & laneMask))
				else
				begin
					valueErrors++;
					$display("ERROR %0t: store addr %h be %b data %h, expected addr %h be %b data %h",
						$time, dmemAddr, dmemByteEnable, dmemWriteData,
						expected.addr, expected.be, expected.data);
				end
			end
		end
		// First edge out of reset still fetches address 0
		if (!reset && !resetSeen)
		begin
			resetSeen = 1'b1;
			assert (imemAddr === 32'd0 && dmemWrite === 1'b0)
			else
			begin
				valueErrors++;
				$display("ERROR %0t: first edge after reset, PC %h store %b", $time, imemAddr, dmemWrite);
			end
		end
	end

	// Mid-cycle, values settled
	always @(negedge clk)
	begin
		if (reset)
		begin
			assert (imemAddr === 32'd0 && dmemWrite === 1'b0)
			else
			begin
				valueErrors++;
				$display("ERROR %0t: in reset, PC %h store %b", $time, imemAddr, dmemWrite);
			end
		end
		else
		begin
			assert (imemAddr[1:0] === 2'b00)
			else
			begin
				valueErrors++;
				$display("ERROR %0t: fetch address %h not word aligned", $time, imemAddr);
			end
			// Read strobe on loads only
			assert (dmemRead === readsDataMemory(imemData))
			else
			begin
				valueErrors++;
				$display("ERROR %0t: read strobe %b for instruction %h", $time, dmemRead, imemData);
			end
		end
	end

	task automatic finishRun();
		$display("Stores checked %0d, value errors %0d, other errors %0d",
			storesSeen, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		resetSeen = 1'b0;
		seed = seedValue;
		for (int i = 0; i < 1024; i++)
		begin
			rnd = $random(seed);
			dmem[i] = rnd[7:0];
		end
		buildProgram();
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		reset = 1'b0;
		// Done once the core sits in its final loop
		do
			@(negedge clk);
		while (imemAddr !== haltAddr);
		if (expQ.size() != 0)
		begin
			otherErrors++;
			$display("Program ended with %0d expected stores never seen", expQ.size());
		end
		finishRun();
	end

	// Watchdog, four cycles per instruction of the program
	initial
	begin
		#1;
		repeat (progLen * 4 + resetCycles) @(posedge clk);
		otherErrors++;
		$display("Timeout: core did not reach its final loop within %0d cycles",
			progLen * 4 + resetCycles);
		finishRun();
	end

endmodule

/* sim.f */
+incdir+include
rtl/MipsIsaPkg.sv
rtl/MipsCtrlPkg.sv
rtl/ControlUnit.sv
rtl/RegisterFile.sv
rtl/Alu.sv
rtl/MemoryAligner.sv
rtl/MipsCore.sv
verification/MipsCoreTb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  # Packages first, then the datapath blocks and the top level
  - rtl/MipsIsaPkg.sv
  - rtl/MipsCtrlPkg.sv
  - rtl/ControlUnit.sv
  - rtl/RegisterFile.sv
  - rtl/Alu.sv
  - rtl/MemoryAligner.sv
  - rtl/MipsCore.sv

  # Testbench with its program header
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/MipsCoreTb.sv
